//--- design/uf_decoder_pkg.sv
package uf_decoder_pkg;

    // Chain of Z ancillas with a boundary at each end
    localparam int num_ancillas    = 8;
    localparam int num_edges       = num_ancillas + 1;
    localparam int address_width   = 3;
    localparam int stage_width     = 3;
    localparam int chain_neighbors = 2;

    // Edge growth in half-steps
    localparam int growth_width = 2;
    localparam logic [growth_width-1:0] grow_full = 2'd2;

    // Controller stage timing
    localparam int count_width = 3;
    localparam logic [count_width-1:0] loading_cycles    = 3'd2;
    localparam logic [count_width-1:0] grow_cycles       = 3'd2;
    localparam logic [count_width-1:0] settle_min_cycles = 3'd4;
    localparam logic [count_width-1:0] quiet_cycles      = 3'd3;

    typedef enum logic [stage_width-1:0] {
        stage_idle                = 3'd0,
        stage_measurement_loading = 3'd1,
        stage_grow                = 3'd2,
        stage_merge               = 3'd3,
        stage_peeling             = 3'd4,
        stage_done                = 3'd5
    } stage_t;

    // What one unit shows to one neighbour
    typedef struct packed {
        logic [address_width-1:0] root;
        logic                     parent;        // Receiver is my parent
        logic                     odd_to_child;
        logic                     cluster_parity;
        logic                     touching_boundary;
        logic                     peeling_complete;
        logic                     peeling_m;
        logic                     peeling_parity_completed;
    } pu_exposed_t;

endpackage

//--- design/uf_edge_if.sv
`timescale 1ns/10ps

interface uf_edge_if;
    import uf_decoder_pkg::*;

    pu_exposed_t left_data;   // From the lower-index unit
    pu_exposed_t right_data;  // From the upper-index unit
    logic        left_increase;
    logic        right_increase;
    logic        left_error;
    logic        right_error;
    logic        fully_grown;
    logic        is_boundary;

    modport left (
        output left_data, left_increase, left_error,
        input  right_data, fully_grown, is_boundary
    );

    modport right (
        output right_data, right_increase, right_error,
        input  left_data, fully_grown, is_boundary
    );

    modport link (
        input  left_increase, right_increase, left_error, right_error,
        output fully_grown, is_boundary
    );

endinterface

//--- design/root_min_select.sv
`timescale 1ns/10ps

module root_min_select #(
    parameter int count = 2
) (
    input  logic [count-1:0][uf_decoder_pkg::address_width-1:0] values,
    input  logic [count-1:0]                                     valids,
    output logic [uf_decoder_pkg::address_width-1:0]             result,
    output logic [count-1:0]                                     winners
);

    logic found;

    // Strict compare keeps the lowest index on a tie
    always_comb begin
        found   = 1'b0;
        result  = '0;
        winners = '0;
        for (int i = 0; i < count; i++) begin
            if (valids[i] && (!found || values[i] < result)) begin
                found      = 1'b1;
                result     = values[i];
                winners    = '0;
                winners[i] = 1'b1;
            end
        end
    end

endmodule

//--- design/neighbor_link.sv
`timescale 1ns/10ps

module neighbor_link #(
    parameter bit to_boundary = 1'b0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  uf_decoder_pkg::stage_t global_stage,
    uf_edge_if.link                edge_bus,
    output logic                   correction
);
    import uf_decoder_pkg::*;

    logic [growth_width-1:0] growth;
    logic [growth_width:0]   sum;

    // Each side adds one half-step
    assign sum = {1'b0, growth}
               + {{growth_width{1'b0}}, edge_bus.left_increase}
               + {{growth_width{1'b0}}, edge_bus.right_increase};

    always_ff @(posedge clk) begin
        if (reset) begin
            growth     <= '0;
            correction <= 1'b0;
        end else if (global_stage == stage_measurement_loading) begin
            growth     <= '0;
            correction <= 1'b0;
        end else begin
            if (global_stage == stage_grow) begin
                growth <= (sum >= {1'b0, grow_full}) ? grow_full : sum[growth_width-1:0];
            end
            if (global_stage == stage_peeling && (edge_bus.left_error || edge_bus.right_error)) begin
                correction <= 1'b1;  // Held until the next load
            end
        end
    end

    assign edge_bus.fully_grown = (growth == grow_full);
    assign edge_bus.is_boundary = to_boundary && edge_bus.fully_grown;

endmodule

//--- design/processing_unit.sv
`timescale 1ns/10ps

module processing_unit #(
    parameter logic [uf_decoder_pkg::address_width-1:0] address = '0,
    parameter int neighbor_count = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  uf_decoder_pkg::stage_t global_stage,
    input  logic                   measurement,
    uf_edge_if.right               nbr_lower,   // Neighbour 0, towards the lower edge
    uf_edge_if.left                nbr_upper,   // Last neighbour, towards the upper edge
    output logic                   odd,
    output logic                   busy
);
    import uf_decoder_pkg::*;

    function automatic logic [neighbor_count-1:0] lowest_one(input logic [neighbor_count-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    pu_exposed_t [neighbor_count-1:0] nbr_in;
    pu_exposed_t [neighbor_count-1:0] nbr_out;

    logic [neighbor_count-1:0][address_width-1:0] nbr_root;
    logic [neighbor_count-1:0] child_of;        // Neighbour names me as its parent
    logic [neighbor_count-1:0] parent_odd;
    logic [neighbor_count-1:0] child_parity;
    logic [neighbor_count-1:0] child_boundary;
    logic [neighbor_count-1:0] child_complete;
    logic [neighbor_count-1:0] child_m;
    logic [neighbor_count-1:0] parent_ppc;
    logic [neighbor_count-1:0] fully_grown;
    logic [neighbor_count-1:0] is_boundary;
    logic [neighbor_count-1:0] error_vec;

    stage_t                    stage;
    stage_t                    last_stage;
    logic                      m;
    logic [address_width-1:0]  root;
    logic [neighbor_count-1:0] parent_vector;
    logic [neighbor_count-1:0] odd_to_children;
    logic                      cluster_parity;
    logic                      cluster_touching_boundary;
    logic                      peeling_complete;
    logic                      peeling_m;
    logic                      peeling_parity_completed;

    logic [address_width-1:0]  min_root;
    logic [neighbor_count-1:0] winners;
    logic                      adopt;
    logic                      has_parent;
    logic                      parent_is_odd;
    logic                      next_cluster_parity;
    logic                      next_touching;
    logic                      merge_odd;
    logic                      at_boundary;
    logic [neighbor_count-1:0] boundary_child;
    logic                      not_done;
    logic                      increase;

    assign nbr_in[0]                  = nbr_lower.left_data;
    assign nbr_in[neighbor_count-1]   = nbr_upper.right_data;
    assign fully_grown[0]             = nbr_lower.fully_grown;
    assign fully_grown[neighbor_count-1] = nbr_upper.fully_grown;
    assign is_boundary[0]             = nbr_lower.is_boundary;
    assign is_boundary[neighbor_count-1] = nbr_upper.is_boundary;

    always_comb begin
        for (int k = 0; k < neighbor_count; k++) begin
            nbr_root[k]       = nbr_in[k].root;
            child_of[k]       = nbr_in[k].parent;
            parent_odd[k]     = nbr_in[k].odd_to_child;
            child_parity[k]   = nbr_in[k].cluster_parity;
            child_boundary[k] = nbr_in[k].touching_boundary;
            child_complete[k] = nbr_in[k].peeling_complete;
            child_m[k]        = nbr_in[k].peeling_m;
            parent_ppc[k]     = nbr_in[k].peeling_parity_completed;

            nbr_out[k].root                     = root;
            nbr_out[k].parent                   = parent_vector[k];
            nbr_out[k].odd_to_child             = odd_to_children[k];
            nbr_out[k].cluster_parity           = cluster_parity;
            nbr_out[k].touching_boundary        = cluster_touching_boundary;
            nbr_out[k].peeling_complete         = peeling_complete;
            nbr_out[k].peeling_m                = peeling_m;
            nbr_out[k].peeling_parity_completed = peeling_parity_completed;
        end
    end

    assign nbr_lower.right_data     = nbr_out[0];
    assign nbr_upper.left_data      = nbr_out[neighbor_count-1];
    assign nbr_lower.right_increase = increase;
    assign nbr_upper.left_increase  = increase;
    assign nbr_lower.right_error    = error_vec[0];
    assign nbr_upper.left_error     = error_vec[neighbor_count-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= stage_idle;
            last_stage <= stage_idle;
        end else begin
            stage      <= global_stage;
            last_stage <= stage;
        end
    end

    // One half-step per grow stage
    assign increase = odd && stage == stage_grow && last_stage != stage_grow;

    root_min_select #(
        .count (neighbor_count)
    ) u_root_min_select (
        .values  (nbr_root),
        .valids  (fully_grown & ~is_boundary),
        .result  (min_root),
        .winners (winners)
    );

    assign adopt               = (|winners) && min_root < root;
    assign has_parent          = |parent_vector;
    assign parent_is_odd       = |(parent_vector & parent_odd);
    assign next_cluster_parity = (^(child_of & child_parity)) ^ m;
    assign next_touching       = (|(child_of & child_boundary)) | (|is_boundary);
    assign merge_odd           = has_parent ? parent_is_odd
                                            : (next_cluster_parity && !next_touching);
    assign at_boundary         = |is_boundary;
    assign boundary_child      = lowest_one(child_of & child_boundary);

    always_ff @(posedge clk) begin
        if (stage == stage_measurement_loading) begin
            m                         <= measurement;
            root                      <= address;
            parent_vector             <= '0;
            cluster_parity            <= measurement;
            cluster_touching_boundary <= 1'b0;
        end else if (stage == stage_merge) begin
            if (adopt) begin
                root          <= min_root;
                parent_vector <= winners;
            end
            cluster_parity            <= next_cluster_parity;
            cluster_touching_boundary <= next_touching;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            odd             <= 1'b0;
            odd_to_children <= '0;
        end else if (stage == stage_measurement_loading) begin
            odd             <= measurement;
            odd_to_children <= {neighbor_count{measurement}};
        end else if (stage == stage_merge) begin
            odd             <= merge_odd;
            odd_to_children <= {neighbor_count{merge_odd}};
        end else if (stage == stage_peeling) begin
            if (!has_parent) begin  // Root starts the path to the boundary
                odd             <= next_cluster_parity;
                odd_to_children <= (next_cluster_parity && !at_boundary) ? boundary_child : '0;
            end else if (parent_is_odd) begin
                odd             <= at_boundary;
                odd_to_children <= at_boundary ? '0 : boundary_child;
            end else begin
                odd             <= 1'b0;
                odd_to_children <= '0;
            end
        end
    end

    assign not_done = (|(child_of & ~child_complete)) || !peeling_parity_completed;

    always_ff @(posedge clk) begin
        if (reset || stage == stage_measurement_loading) begin
            peeling_parity_completed <= 1'b0;
            peeling_complete         <= 1'b0;
            peeling_m                <= 1'b0;
        end else if (stage == stage_peeling) begin
            peeling_parity_completed <= !has_parent || (|(parent_vector & parent_ppc));
            peeling_complete         <= !not_done;
            if (last_stage != stage_peeling) begin
                peeling_m <= m;
            end else if (!not_done) begin
                peeling_m <= m ^ (^(child_of & child_m)) ^ odd;  // Subtree parity left over
            end
        end
    end

    assign error_vec = (stage == stage_peeling && !not_done)
                     ? ((child_of & child_m) | (odd ? lowest_one(is_boundary) : '0))
                     : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (stage == stage_merge) begin
            busy <= adopt
                 || next_cluster_parity != cluster_parity
                 || next_touching != cluster_touching_boundary
                 || merge_odd != odd;
        end else if (stage == stage_peeling) begin
            busy <= not_done;
        end
    end

endmodule

//--- design/decode_controller.sv
`timescale 1ns/10ps

module decode_controller (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  logic                   any_busy,
    input  logic                   any_odd,
    output uf_decoder_pkg::stage_t global_stage,
    output logic                   ack,
    output logic                   load
);
    import uf_decoder_pkg::*;

    stage_t                 next_stage;
    logic [count_width-1:0] stage_cycles;  // Cycles spent in the current stage
    logic [count_width-1:0] quiet;
    logic [count_width-1:0] quiet_now;
    logic                   settled;

    // Busy count includes this cycle
    assign quiet_now = any_busy ? '0 : ((quiet == quiet_cycles) ? quiet : quiet + 1'b1);
    assign settled   = stage_cycles >= settle_min_cycles - 1'b1 && quiet_now == quiet_cycles;

    always_comb begin
        next_stage = global_stage;
        case (global_stage)
            stage_idle: begin
                if (req) next_stage = stage_measurement_loading;
            end
            stage_measurement_loading: begin
                if (stage_cycles == loading_cycles - 1'b1) next_stage = stage_grow;
            end
            stage_grow: begin
                if (stage_cycles == grow_cycles - 1'b1) next_stage = stage_merge;
            end
            stage_merge: begin
                if (settled) next_stage = any_odd ? stage_grow : stage_peeling;
            end
            stage_peeling: begin
                if (settled) next_stage = stage_done;
            end
            stage_done: begin
                if (!req) next_stage = stage_idle;  // Waits out a held req
            end
            default: next_stage = stage_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage <= stage_idle;
            stage_cycles <= '0;
            quiet        <= '0;
            ack          <= 1'b0;
            load         <= 1'b0;
        end else begin
            global_stage <= next_stage;
            if (next_stage != global_stage) begin
                stage_cycles <= '0;
                quiet        <= '0;
            end else begin
                stage_cycles <= (&stage_cycles) ? stage_cycles : stage_cycles + 1'b1;
                quiet        <= quiet_now;
            end
            load <= global_stage == stage_idle && next_stage == stage_measurement_loading;
            ack  <= global_stage == stage_done;
        end
    end

endmodule

//--- design/uf_decoder_top.sv
`timescale 1ns/10ps

module uf_decoder_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req,
    input  logic [uf_decoder_pkg::num_ancillas-1:0] syndrome,
    output logic                                ack,
    output logic [uf_decoder_pkg::num_edges-1:0]    correction
);
    import uf_decoder_pkg::*;

    stage_t                  global_stage;
    logic                    load;
    logic                    any_busy;
    logic                    any_odd;
    logic [num_ancillas-1:0] measurement;
    logic [num_ancillas-1:0] busy;
    logic [num_ancillas-1:0] odd;

    uf_edge_if edges [num_edges] ();

    always_ff @(posedge clk) begin
        if (load) measurement <= syndrome;
    end

    assign any_busy = |busy;
    assign any_odd  = |odd;

    // Nothing sits beyond the boundaries
    assign edges[0].left_data                = '0;
    assign edges[0].left_increase            = 1'b0;
    assign edges[0].left_error               = 1'b0;
    assign edges[num_edges-1].right_data     = '0;
    assign edges[num_edges-1].right_increase = 1'b0;
    assign edges[num_edges-1].right_error    = 1'b0;

    decode_controller u_decode_controller (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .any_busy     (any_busy),
        .any_odd      (any_odd),
        .global_stage (global_stage),
        .ack          (ack),
        .load         (load)
    );

    for (genvar i = 0; i < num_ancillas; i++) begin : g_unit
        processing_unit #(
            .address        (address_width'(i)),
            .neighbor_count (chain_neighbors)
        ) u_processing_unit (
            .clk          (clk),
            .reset        (reset),
            .global_stage (global_stage),
            .measurement  (measurement[i]),
            .nbr_lower    (edges[i]),
            .nbr_upper    (edges[i+1]),
            .odd          (odd[i]),
            .busy         (busy[i])
        );
    end

    for (genvar e = 0; e < num_edges; e++) begin : g_link
        neighbor_link #(
            .to_boundary (e == 0 || e == num_edges - 1)
        ) u_neighbor_link (
            .clk          (clk),
            .reset        (reset),
            .global_stage (global_stage),
            .edge_bus     (edges[e]),
            .correction   (correction[e])
        );
    end

endmodule

//--- tests/uf_decoder_assertions.sv
`timescale 1ns/10ps

module uf_decoder_assertions (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 req,
    input logic                                 ack,
    input logic [uf_decoder_pkg::num_edges-1:0] correction
);

    int unsigned failure_count = 0;

    // ack only answers a raised req
    ack_rise_with_req: assert property (
        @(posedge clk) disable iff (reset) $rose(ack) |-> $past(req)
    ) else begin
        $error("ack rose while req was low");
        failure_count++;
    end

    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (reset) $fell(ack) |-> !req && !$past(req)
    ) else begin
        $error("ack fell before req had been low");
        failure_count++;
    end

    // Result held through the whole ack phase
    correction_stable: assert property (
        @(posedge clk) disable iff (reset) ack && $past(ack) |-> $stable(correction)
    ) else begin
        $error("correction changed while ack was high");
        failure_count++;
    end

    ack_low_after_reset: assert property (
        @(posedge clk) reset |=> !ack
    ) else begin
        $error("ack was high in the cycle after reset");
        failure_count++;
    end

endmodule

//--- tests/uf_decoder_tb.sv
`timescale 1ns/10ps

module uf_decoder_tb;
    import uf_decoder_pkg::*;

    localparam int          clock_period   = 100;
    localparam int          drive_delay    = 5;
    localparam int          reset_cycles   = 5;
    localparam int          timeout_cycles = 2000;
    localparam int          random_count   = 16;
    localparam int          hold_cycles    = 20;
    localparam logic [31:0] lfsr_seed      = 32'h8da7b94c;

    logic                    clk;
    logic                    reset;
    logic                    req;
    logic [num_ancillas-1:0] syndrome;
    logic                    ack;
    logic [num_edges-1:0]    correction;

    logic [31:0]             lfsr;
    logic [num_edges-1:0]    result;
    logic [num_ancillas-1:0] random_syndrome;
    logic [num_ancillas-1:0] file_syndrome;
    logic [num_edges-1:0]    file_correction;
    int                      fd;
    int                      vectors;

    uf_decoder_top u_uf_decoder_top (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .syndrome   (syndrome),
        .ack        (ack),
        .correction (correction)
    );

    bind uf_decoder_top uf_decoder_assertions u_uf_decoder_assertions (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .ack        (ack),
        .correction (correction)
    );

    always #(clock_period / 2) clk = ~clk;

    // Taps for x^32 + x^22 + x^2 + x + 1 with the new bit entering at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // Ancilla i sees edges i and i+1
    function automatic logic [num_ancillas-1:0] implied_syndrome(input logic [num_edges-1:0] c);
        return c[num_ancillas-1:0] ^ c[num_edges-1:1];
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic wait_for_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < timeout_cycles) begin
            @(posedge clk);
            #(drive_delay);
            cycles++;
        end
        assert (ack === level)
            else stop_with_failure(level ? "Timeout: ack never rose" : "Timeout: ack never fell");
    endtask

    // Full four-phase transfer with req kept high for hold extra cycles after ack
    task automatic decode(input logic [num_ancillas-1:0] syn, input int hold,
                          output logic [num_edges-1:0] res);
        @(posedge clk);
        #(drive_delay);
        syndrome = syn;
        @(posedge clk);
        #(drive_delay);
        req = 1'b1;
        wait_for_ack(1'b1);
        res = correction;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #(drive_delay);
            assert (ack === 1'b1)
                else stop_with_failure($sformatf("[ERROR] ack: expected 0x1, got 0x%0h", ack));
            assert (correction === res)
                else stop_with_failure($sformatf("[ERROR] correction: expected 0x%03h, got 0x%03h",
                                                 res, correction));
        end
        req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic check_consistent(input logic [num_ancillas-1:0] syn,
                                    input logic [num_edges-1:0] res);
        assert (implied_syndrome(res) === syn)
            else stop_with_failure($sformatf(
                "[ERROR] correction: 0x%03h gives syndrome 0x%02h, expected 0x%02h",
                res, implied_syndrome(res), syn));
    endtask

    task automatic next_random_syndrome(output logic [num_ancillas-1:0] value);
        for (int b = 0; b < num_ancillas; b++) begin
            lfsr     = lfsr_step(lfsr);
            value[b] = lfsr[0];
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        req      = 1'b0;
        syndrome = '0;
        lfsr     = lfsr_seed;
        vectors  = 0;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        reset = 1'b0;

        assert (ack === 1'b0)
            else stop_with_failure($sformatf("[ERROR] ack: expected 0x0, got 0x%0h", ack));
        assert (correction === '0)
            else stop_with_failure($sformatf("[ERROR] correction: expected 0x000, got 0x%03h",
                                             correction));

        decode('0, 0, result);
        assert (result === '0)
            else stop_with_failure($sformatf("[ERROR] correction: expected 0x000, got 0x%03h",
                                             result));

        // Held req must freeze ack and the result
        decode(8'h18, hold_cycles, result);
        check_consistent(8'h18, result);

        fd = $fopen("tests/uf_decoder_tests.txt", "r");
        assert (fd != 0)
            else stop_with_failure("Could not open tests/uf_decoder_tests.txt");
        while ($fscanf(fd, "%h %h\n", file_syndrome, file_correction) == 2) begin
            decode(file_syndrome, 0, result);
            assert (result === file_correction)
                else stop_with_failure($sformatf(
                    "[ERROR] correction: syndrome 0x%02h, expected 0x%03h, got 0x%03h",
                    file_syndrome, file_correction, result));
            check_consistent(file_syndrome, result);
            vectors++;
        end
        $fclose(fd);
        assert (vectors > 0)
            else stop_with_failure("No vectors were read from tests/uf_decoder_tests.txt");

        for (int n = 0; n < random_count; n++) begin
            next_random_syndrome(random_syndrome);
            decode(random_syndrome, 0, result);
            check_consistent(random_syndrome, result);
        end

        if (u_uf_decoder_top.u_uf_decoder_assertions.failure_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure("Concurrent assertions on the handshake failed during the run");
        end
    end

endmodule

//--- tests/uf_decoder_tests.txt
00 000
03 002
18 010
c0 080
01 001
80 100
02 003
0a 00c
24 038
33 022

//--- files.f
design/uf_decoder_pkg.sv
design/uf_edge_if.sv
design/root_min_select.sv
design/neighbor_link.sv
design/processing_unit.sv
design/decode_controller.sv
design/uf_decoder_top.sv
tests/uf_decoder_assertions.sv
tests/uf_decoder_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = uf_decoder_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
RUN_FLAGS  = +verilator+error+limit+100
PASS_MSG   = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
